/* hw/rv5_pkg.sv */
package rv5_pkg;

	// ALU operations
	typedef enum logic [3:0] {
		alu_add,
		alu_sub,
		alu_and,
		alu_or,
		alu_xor,
		alu_sll,
		alu_srl,
		alu_slt,
		alu_pass_b
	} alu_op_e;

	// Data bus commands
	typedef enum logic [1:0] {
		bus_none,
		bus_load,
		bus_store
	} bus_cmd_e;

	// Writeback source
	typedef enum logic [1:0] {
		wb_none,
		wb_alu,
		wb_mem
	} wb_sel_e;

	// Major opcodes of the supported subset
	localparam logic [6:0] op_lui   = 7'b0110111;
	localparam logic [6:0] op_imm   = 7'b0010011;
	localparam logic [6:0] op_reg   = 7'b0110011;
	localparam logic [6:0] op_load  = 7'b0000011;
	localparam logic [6:0] op_store = 7'b0100011;

	// addi x0, x0, 0
	localparam logic [31:0] noop_inst = 32'h0000_0013;
	localparam logic [4:0]  zero_reg  = 5'd0;

	typedef struct packed {
		logic [31:0] pc;
		logic [31:0] inst;
		logic        vld;
	} if_id_t;

	typedef struct packed {
		logic [31:0] alu_opa;
		logic [31:0] alu_opb;
		alu_op_e     alu_func;
		logic [31:0] mem_din;
		bus_cmd_e    mem_cmd;
		wb_sel_e     wb_sel;
		logic [4:0]  rd;
		logic        vld;
	} id_ex_t;

	typedef struct packed {
		logic [31:0] alu_res;
		logic [31:0] mem_din;
		bus_cmd_e    mem_cmd;
		wb_sel_e     wb_sel;
		logic [4:0]  rd;
		logic        vld;
	} ex_mem_t;

	typedef struct packed {
		logic [31:0] wb_data;
		logic [4:0]  rd;
		logic        vld;
	} mem_wb_t;

	// Bubble values loaded into the stage registers on reset
	localparam if_id_t if_id_reset = '{
		pc:   32'h0,
		inst: noop_inst,
		vld:  1'b0
	};

	localparam id_ex_t id_ex_reset = '{
		alu_opa:  32'h0,
		alu_opb:  32'h0,
		alu_func: alu_add,
		mem_din:  32'h0,
		mem_cmd:  bus_none,
		wb_sel:   wb_none,
		rd:       zero_reg,
		vld:      1'b0
	};

	localparam ex_mem_t ex_mem_reset = '{
		alu_res: 32'h0,
		mem_din: 32'h0,
		mem_cmd: bus_none,
		wb_sel:  wb_none,
		rd:      zero_reg,
		vld:     1'b0
	};

	localparam mem_wb_t mem_wb_reset = '{
		wb_data: 32'h0,
		rd:      zero_reg,
		vld:     1'b0
	};

endpackage

/* hw/pipe_reg.sv */
`timescale 1ns/100ps

module pipe_reg #(
	parameter type payload_t = logic,
	parameter payload_t reset_val = '0
) (
	input  logic     clk,
	input  logic     rst,
	input  payload_t d,
	output payload_t q
);

	// Advances every cycle, there is no stall
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			q <= reset_val;
		end else begin
			q <= d;
		end
	end

endmodule

/* hw/if_stage.sv */
`timescale 1ns/100ps

module if_stage (
	input  rv5_pkg::if_id_t if_id,
	input  logic [31:0]     IM_inst,
	output logic [31:0]     IF_pc,
	output rv5_pkg::if_id_t if_out
);

	// Next sequential fetch, no branches in this core
	assign IF_pc = if_id.pc + 32'd4;

	// Instruction memory answers in the same cycle
	always_comb begin
		if_out.pc   = IF_pc;
		if_out.inst = IM_inst;
		// Reset holds the register, so anything fetched afterwards is real
		if_out.vld  = 1'b1;
	end

endmodule

/* hw/id_stage.sv */
`timescale 1ns/100ps

module id_stage (
	input  rv5_pkg::if_id_t if_id,
	input  logic [31:0]     rs1_data,
	input  logic [31:0]     rs2_data,
	output logic [4:0]      rs1,
	output logic [4:0]      rs2,
	output rv5_pkg::id_ex_t id_out
);

	logic [6:0]  opcode;
	logic [2:0]  funct3;
	logic [6:0]  funct7;
	logic [4:0]  rd;
	logic [31:0] imm_i;
	logic [31:0] imm_s;
	logic [31:0] imm_u;
	logic        known;

	assign opcode = if_id.inst[6:0];
	assign rd     = if_id.inst[11:7];
	assign funct3 = if_id.inst[14:12];
	assign rs1    = if_id.inst[19:15];
	assign rs2    = if_id.inst[24:20];
	assign funct7 = if_id.inst[31:25];

	// Sign extended immediates
	assign imm_i = {{20{if_id.inst[31]}}, if_id.inst[31:20]};
	assign imm_s = {{20{if_id.inst[31]}}, if_id.inst[31:25], if_id.inst[11:7]};
	assign imm_u = {if_id.inst[31:12], 12'h000};

	always_comb begin
		id_out.alu_opa  = rs1_data;
		id_out.alu_opb  = rs2_data;
		id_out.alu_func = rv5_pkg::alu_add;
		id_out.mem_din  = rs2_data;
		id_out.mem_cmd  = rv5_pkg::bus_none;
		id_out.wb_sel   = rv5_pkg::wb_none;
		id_out.rd       = rd;
		known           = 1'b0;

		case (opcode)
			rv5_pkg::op_lui: begin
				id_out.alu_opb  = imm_u;
				id_out.alu_func = rv5_pkg::alu_pass_b;
				id_out.wb_sel   = rv5_pkg::wb_alu;
				known           = 1'b1;
			end
			rv5_pkg::op_imm: begin
				// Only addi is supported
				if (funct3 == 3'b000) begin
					id_out.alu_opb = imm_i;
					id_out.wb_sel  = rv5_pkg::wb_alu;
					known          = 1'b1;
				end
			end
			rv5_pkg::op_reg: begin
				id_out.wb_sel = rv5_pkg::wb_alu;
				known         = 1'b1;
				case ({funct7, funct3})
					10'b0000000_000: id_out.alu_func = rv5_pkg::alu_add;
					10'b0100000_000: id_out.alu_func = rv5_pkg::alu_sub;
					10'b0000000_111: id_out.alu_func = rv5_pkg::alu_and;
					10'b0000000_110: id_out.alu_func = rv5_pkg::alu_or;
					10'b0000000_100: id_out.alu_func = rv5_pkg::alu_xor;
					10'b0000000_001: id_out.alu_func = rv5_pkg::alu_sll;
					10'b0000000_101: id_out.alu_func = rv5_pkg::alu_srl;
					10'b0000000_010: id_out.alu_func = rv5_pkg::alu_slt;
					default:         known = 1'b0;
				endcase
			end
			rv5_pkg::op_load: begin
				// Word loads only, address is rs1 plus offset
				if (funct3 == 3'b010) begin
					id_out.alu_opb = imm_i;
					id_out.mem_cmd = rv5_pkg::bus_load;
					id_out.wb_sel  = rv5_pkg::wb_mem;
					known          = 1'b1;
				end
			end
			rv5_pkg::op_store: begin
				if (funct3 == 3'b010) begin
					id_out.alu_opb = imm_s;
					id_out.mem_cmd = rv5_pkg::bus_store;
					id_out.rd      = rv5_pkg::zero_reg;
					known          = 1'b1;
				end
			end
			default: known = 1'b0;
		endcase

		id_out.vld = if_id.vld && known;

		// Unknown opcodes travel on as bubbles
		if (!id_out.vld) begin
			id_out.mem_cmd = rv5_pkg::bus_none;
			id_out.wb_sel  = rv5_pkg::wb_none;
			id_out.rd      = rv5_pkg::zero_reg;
		end
	end

endmodule

/* hw/ex_stage.sv */
`timescale 1ns/100ps

module ex_stage (
	input  rv5_pkg::id_ex_t  id_ex,
	output rv5_pkg::ex_mem_t ex_out
);

	logic [4:0] shamt;

	assign shamt = id_ex.alu_opb[4:0];

	always_comb begin
		case (id_ex.alu_func)
			rv5_pkg::alu_add:    ex_out.alu_res = id_ex.alu_opa + id_ex.alu_opb;
			rv5_pkg::alu_sub:    ex_out.alu_res = id_ex.alu_opa - id_ex.alu_opb;
			rv5_pkg::alu_and:    ex_out.alu_res = id_ex.alu_opa & id_ex.alu_opb;
			rv5_pkg::alu_or:     ex_out.alu_res = id_ex.alu_opa | id_ex.alu_opb;
			rv5_pkg::alu_xor:    ex_out.alu_res = id_ex.alu_opa ^ id_ex.alu_opb;
			rv5_pkg::alu_sll:    ex_out.alu_res = id_ex.alu_opa << shamt;
			rv5_pkg::alu_srl:    ex_out.alu_res = id_ex.alu_opa >> shamt;
			rv5_pkg::alu_slt: begin
				// Signed compare
				ex_out.alu_res = {31'h0, $signed(id_ex.alu_opa) < $signed(id_ex.alu_opb)};
			end
			rv5_pkg::alu_pass_b: ex_out.alu_res = id_ex.alu_opb;
			default:             ex_out.alu_res = 32'h0;
		endcase

		// Control fields pass through untouched
		ex_out.mem_din = id_ex.mem_din;
		ex_out.mem_cmd = id_ex.mem_cmd;
		ex_out.wb_sel  = id_ex.wb_sel;
		ex_out.rd      = id_ex.rd;
		ex_out.vld     = id_ex.vld;
	end

endmodule

/* hw/mem_stage.sv */
`timescale 1ns/100ps

module mem_stage (
	input  rv5_pkg::ex_mem_t ex_mem,
	input  logic [31:0]      DM_mem_dout,
	output logic [31:0]      MEM_mem_addr,
	output rv5_pkg::bus_cmd_e MEM_mem_cmd,
	output logic [31:0]      MEM_mem_din,
	output rv5_pkg::mem_wb_t mem_out
);

	// Address always comes from the ALU
	assign MEM_mem_addr = ex_mem.alu_res;
	assign MEM_mem_din  = ex_mem.mem_din;
	assign MEM_mem_cmd  = ex_mem.vld ? ex_mem.mem_cmd : rv5_pkg::bus_none;

	always_comb begin
		if (ex_mem.wb_sel == rv5_pkg::wb_mem) begin
			mem_out.wb_data = DM_mem_dout;
		end else begin
			mem_out.wb_data = ex_mem.alu_res;
		end
		mem_out.rd  = ex_mem.rd;
		// Stores and bubbles write nothing back
		mem_out.vld = ex_mem.vld && (ex_mem.wb_sel != rv5_pkg::wb_none);
	end

endmodule

/* hw/register_file.sv */
`timescale 1ns/100ps

module register_file (
	input  logic             clk,
	input  logic             rst,
	input  rv5_pkg::mem_wb_t wr,
	input  logic [4:0]       rs1,
	input  logic [4:0]       rs2,
	output logic [31:0]      rs1_data,
	output logic [31:0]      rs2_data
);

	logic [31:0] regs [32];
	logic        wr_en;

	assign wr_en = wr.vld && (wr.rd != rv5_pkg::zero_reg);

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= 32'h0;
			end
		end else if (wr_en) begin
			regs[wr.rd] <= wr.wb_data;
		end
	end

	// x0 reads zero, a write in flight is seen by the reader
	always_comb begin
		if (rs1 == rv5_pkg::zero_reg) begin
			rs1_data = 32'h0;
		end else if (wr_en && (wr.rd == rs1)) begin
			rs1_data = wr.wb_data;
		end else begin
			rs1_data = regs[rs1];
		end

		if (rs2 == rv5_pkg::zero_reg) begin
			rs2_data = 32'h0;
		end else if (wr_en && (wr.rd == rs2)) begin
			rs2_data = wr.wb_data;
		end else begin
			rs2_data = regs[rs2];
		end
	end

endmodule

/* hw/processor.sv */
`timescale 1ns/100ps

module processor #(
	parameter logic [31:0] boot_addr = 32'h0
) (
	input  logic              clk,
	input  logic              rst,

	// Instruction memory
	input  logic [31:0]       IM_inst,
	output logic [31:0]       IF_pc,

	// Data memory
	input  logic [31:0]       DM_mem_dout,
	output logic [31:0]       MEM_mem_addr,
	output rv5_pkg::bus_cmd_e MEM_mem_cmd,
	output logic [31:0]       MEM_mem_din
);

	// First fetch lands on boot_addr
	localparam rv5_pkg::if_id_t if_id_rst = '{
		pc:   boot_addr - 32'd4,
		inst: rv5_pkg::if_id_reset.inst,
		vld:  rv5_pkg::if_id_reset.vld
	};

	rv5_pkg::if_id_t  if_out;
	rv5_pkg::if_id_t  if_id;
	rv5_pkg::id_ex_t  id_out;
	rv5_pkg::id_ex_t  id_ex;
	rv5_pkg::ex_mem_t ex_out;
	rv5_pkg::ex_mem_t ex_mem;
	rv5_pkg::mem_wb_t mem_out;
	rv5_pkg::mem_wb_t mem_wb;

	logic [4:0]  rs1;
	logic [4:0]  rs2;
	logic [31:0] rs1_data;
	logic [31:0] rs2_data;

	if_stage if_stage_i (
		.if_id   (if_id),
		.IM_inst (IM_inst),
		.IF_pc   (IF_pc),
		.if_out  (if_out)
	);

	pipe_reg #(
		.payload_t (rv5_pkg::if_id_t),
		.reset_val (if_id_rst)
	) if_id_i (
		.clk (clk),
		.rst (rst),
		.d   (if_out),
		.q   (if_id)
	);

	id_stage id_stage_i (
		.if_id    (if_id),
		.rs1_data (rs1_data),
		.rs2_data (rs2_data),
		.rs1      (rs1),
		.rs2      (rs2),
		.id_out   (id_out)
	);

	pipe_reg #(
		.payload_t (rv5_pkg::id_ex_t),
		.reset_val (rv5_pkg::id_ex_reset)
	) id_ex_i (
		.clk (clk),
		.rst (rst),
		.d   (id_out),
		.q   (id_ex)
	);

	ex_stage ex_stage_i (
		.id_ex  (id_ex),
		.ex_out (ex_out)
	);

	pipe_reg #(
		.payload_t (rv5_pkg::ex_mem_t),
		.reset_val (rv5_pkg::ex_mem_reset)
	) ex_mem_i (
		.clk (clk),
		.rst (rst),
		.d   (ex_out),
		.q   (ex_mem)
	);

	mem_stage mem_stage_i (
		.ex_mem       (ex_mem),
		.DM_mem_dout  (DM_mem_dout),
		.MEM_mem_addr (MEM_mem_addr),
		.MEM_mem_cmd  (MEM_mem_cmd),
		.MEM_mem_din  (MEM_mem_din),
		.mem_out      (mem_out)
	);

	pipe_reg #(
		.payload_t (rv5_pkg::mem_wb_t),
		.reset_val (rv5_pkg::mem_wb_reset)
	) mem_wb_i (
		.clk (clk),
		.rst (rst),
		.d   (mem_out),
		.q   (mem_wb)
	);

	// Writeback happens here
	register_file register_file_i (
		.clk      (clk),
		.rst      (rst),
		.wr       (mem_wb),
		.rs1      (rs1),
		.rs2      (rs2),
		.rs1_data (rs1_data),
		.rs2_data (rs2_data)
	);

endmodule

/* sim/processor_tb.sv */
`timescale 1ns/100ps

module processor_tb;

	localparam logic [31:0] boot_addr = 32'h0;
	localparam int prog_len = 200;
	localparam int reset_cycles = 8;
	localparam int clk_period = 8;
	localparam int watchdog_ns = 2 * (reset_cycles + prog_len + 10) * clk_period;
	// Fetch address by which the last store has left the pipeline
	localparam logic [31:0] drain_pc = boot_addr + (prog_len + 6) * 4;

	logic              clk = 1'b0;
	logic              rst;
	logic [31:0]       IM_inst;
	logic [31:0]       DM_mem_dout;
	logic [31:0]       IF_pc;
	logic [31:0]       MEM_mem_addr;
	rv5_pkg::bus_cmd_e MEM_mem_cmd;
	logic [31:0]       MEM_mem_din;

	logic [31:0] prog [prog_len + 1];
	logic [31:0] dmem [16];
	logic [31:0] mregs [32];
	logic [31:0] mmem [16];
	logic [31:0] lfsr_state = 32'd31;
	logic [31:0] exp_st_addr [$];
	logic [31:0] exp_st_data [$];
	logic [31:0] exp_ld_addr [$];
	int          st_expected;
	int          st_seen;
	logic        after_reset;
	logic [31:0] prev_pc;

	processor #(
		.boot_addr (boot_addr)
	) dut_i (
		.clk          (clk),
		.rst          (rst),
		.IM_inst      (IM_inst),
		.IF_pc        (IF_pc),
		.DM_mem_dout  (DM_mem_dout),
		.MEM_mem_addr (MEM_mem_addr),
		.MEM_mem_cmd  (MEM_mem_cmd),
		.MEM_mem_din  (MEM_mem_din)
	);

	always #(clk_period / 2) clk = ~clk;

	// Instruction memory returns noops past the end of the program
	always_comb begin
		if ((IF_pc >> 2) <= prog_len) begin
			IM_inst = prog[IF_pc >> 2];
		end else begin
			IM_inst = rv5_pkg::noop_inst;
		end
	end

	// Data memory answers loads in the same cycle
	always_comb begin
		DM_mem_dout = dmem[MEM_mem_addr[5:2]];
	end

	always @(posedge clk) begin
		if (MEM_mem_cmd == rv5_pkg::bus_store) begin
			dmem[MEM_mem_addr[5:2]] <= MEM_mem_din;
		end
	end

	function automatic logic [31:0] step_lfsr(input logic [31:0] s);
		// Galois form with taps 32 30 26 25
		if (s[0]) begin
			return (s >> 1) ^ 32'hA300_0000;
		end
		return s >> 1;
	endfunction

	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int k = 0; k < n; k++) begin
			v = {v[30:0], lfsr_state[0]};
			lfsr_state = step_lfsr(lfsr_state);
		end
		return v;
	endfunction

	function automatic logic [31:0] fill_word(input logic [31:0] addr);
		return (addr * 32'h9E37_79B9) ^ 32'hC3A5_0F1E;
	endfunction

	// Source from x0..x7 that avoids the two most recent writers
	function automatic logic [4:0] pick_source(input logic [4:0] h0, input logic [4:0] h1);
		logic [4:0] r;
		r = 5'(take_bits(3));
		while (r == h0 || r == h1) begin
			r = 5'(take_bits(3));
		end
		return r;
	endfunction

	// RV32I register-register semantics
	function automatic logic [31:0] alu_model(input logic [2:0] f3, input logic alt,
		input logic [31:0] a, input logic [31:0] b);
		case (f3)
			3'd0: return alt ? a - b : a + b;
			3'd1: return a << b[4:0];
			3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			3'd4: return a ^ b;
			3'd5: return a >> b[4:0];
			3'd6: return a | b;
			default: return a & b;
		endcase
	endfunction

	task automatic stop_on_failure;
		$display("Checks failed");
		$fatal(1);
	endtask

	task automatic report_mismatch(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		$display("[ERROR] %0t ns %s expected %h actual %h", $time, name, expected, actual);
		stop_on_failure();
	endtask

	task automatic report_failure(input string what);
		$display("%0t ns: %s", $time, what);
		stop_on_failure();
	endtask

	// Builds the program and runs it on the reference model in order
	task automatic build_program;
		logic [31:0] inst;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] res;
		logic [31:0] off;
		logic [31:0] imm;
		logic [4:0]  rd;
		logic [4:0]  rs1;
		logic [4:0]  rs2;
		logic [4:0]  hz0;
		logic [4:0]  hz1;
		logic [3:0]  kind;
		logic [2:0]  f3;
		logic [6:0]  f7;
		logic [6:0]  opc;
		logic        writes;
		hz0 = 5'd31;
		hz1 = 5'd31;
		for (int i = 0; i < 32; i++) begin
			mregs[i] = 32'h0;
		end
		for (int i = 0; i < 16; i++) begin
			mmem[i] = fill_word(i * 4);
			dmem[i] = mmem[i];
		end
		for (int i = 0; i < prog_len; i++) begin
			rd = 5'(take_bits(3));
			rs1 = pick_source(hz0, hz1);
			rs2 = pick_source(hz0, hz1);
			a = mregs[rs1];
			b = mregs[rs2];
			res = 32'h0;
			writes = 1'b1;
			kind = 4'(take_bits(4));
			off = take_bits(4) << 2;
			if (take_bits(8) < 13) begin
				opc = {5'(take_bits(5)), 2'b11};
				if (opc == rv5_pkg::op_lui || opc == rv5_pkg::op_imm ||
					opc == rv5_pkg::op_reg || opc == rv5_pkg::op_load ||
					opc == rv5_pkg::op_store) begin
					opc = 7'b1100011;
				end
				inst = {25'(take_bits(25)), opc};
				writes = 1'b0;
			end else if (kind < 2) begin
				imm = take_bits(20);
				inst = {imm[19:0], rd, rv5_pkg::op_lui};
				res = {imm[19:0], 12'h000};
			end else if (kind < 5) begin
				imm = take_bits(12);
				inst = {imm[11:0], rs1, 3'b000, rd, rv5_pkg::op_imm};
				res = a + {{20{imm[11]}}, imm[11:0]};
			end else if (kind < 10) begin
				f3 = 3'(take_bits(3));
				// No sltu in the subset
				if (f3 == 3'd3) begin
					f3 = 3'd0;
				end
				f7 = (f3 == 3'd0 && take_bits(1) == 32'd1) ? 7'h20 : 7'h00;
				inst = {f7, rs2, rs1, f3, rd, rv5_pkg::op_reg};
				res = alu_model(f3, f7[5], a, b);
			end else if (kind < 12) begin
				inst = {off[11:0], 5'd0, 3'b010, rd, rv5_pkg::op_load};
				res = mmem[off[5:2]];
				exp_ld_addr.push_back(off);
			end else begin
				inst = {off[11:5], rs2, 5'd0, 3'b010, off[4:0], rv5_pkg::op_store};
				exp_st_addr.push_back(off);
				exp_st_data.push_back(b);
				mmem[off[5:2]] = b;
				writes = 1'b0;
			end
			if (writes && rd != 5'd0) begin
				mregs[rd] = res;
			end
			prog[i] = inst;
			hz1 = hz0;
			hz0 = writes ? rd : 5'd31;
		end
		prog[prog_len] = rv5_pkg::noop_inst;
		st_expected = exp_st_addr.size();
	endtask

	// Outputs sampled mid cycle
	always @(negedge clk) begin
		if (rst) begin
			assert (MEM_mem_cmd == rv5_pkg::bus_none)
			else report_mismatch("MEM_mem_cmd", 32'(rv5_pkg::bus_none), 32'(MEM_mem_cmd));
			assert (IF_pc == boot_addr) else report_mismatch("IF_pc", boot_addr, IF_pc);
			after_reset = 1'b1;
		end else begin
			if (after_reset) begin
				assert (MEM_mem_cmd == rv5_pkg::bus_none)
				else report_mismatch("MEM_mem_cmd", 32'(rv5_pkg::bus_none), 32'(MEM_mem_cmd));
				assert (IF_pc == boot_addr) else report_mismatch("IF_pc", boot_addr, IF_pc);
			end else begin
				assert (IF_pc == prev_pc + 32'd4)
				else report_mismatch("IF_pc", prev_pc + 32'd4, IF_pc);
			end
			after_reset = 1'b0;
			prev_pc = IF_pc;

			if (MEM_mem_cmd == rv5_pkg::bus_store) begin
				st_seen++;
				assert (exp_st_addr.size() != 0)
				else report_failure("store on the bus after the last expected store");
				if (exp_st_addr.size() != 0) begin
					assert (MEM_mem_addr == exp_st_addr[0])
					else report_mismatch("MEM_mem_addr", exp_st_addr[0], MEM_mem_addr);
					assert (MEM_mem_din == exp_st_data[0])
					else report_mismatch("MEM_mem_din", exp_st_data[0], MEM_mem_din);
					void'(exp_st_addr.pop_front());
					void'(exp_st_data.pop_front());
				end
			end else if (MEM_mem_cmd == rv5_pkg::bus_load) begin
				assert (exp_ld_addr.size() != 0)
				else report_failure("load on the bus after the last expected load");
				if (exp_ld_addr.size() != 0) begin
					assert (MEM_mem_addr == exp_ld_addr[0])
					else report_mismatch("MEM_mem_addr", exp_ld_addr[0], MEM_mem_addr);
					void'(exp_ld_addr.pop_front());
				end
			end
		end
	end

	initial begin
		rst = 1'b1;
		st_seen = 0;
		after_reset = 1'b0;
		prev_pc = '0;
		build_program();
		repeat (reset_cycles) @(posedge clk);
		rst <= 1'b0;
		wait (IF_pc >= drain_pc);
		repeat (2) @(posedge clk);
		assert (st_seen == st_expected)
		else report_mismatch("store count", 32'(st_expected), 32'(st_seen));
		assert (exp_ld_addr.size() == 0)
		else report_failure("expected loads never appeared on the bus");
		$display("All checks passed");
		$finish;
	end

	initial begin
		#(watchdog_ns);
		$display("Watchdog expired after %0d ns, the program did not drain", watchdog_ns);
		stop_on_failure();
	end

endmodule

/* rv5_pipe.f */
hw/rv5_pkg.sv
hw/pipe_reg.sv
hw/if_stage.sv
hw/id_stage.sv
hw/ex_stage.sv
hw/mem_stage.sv
hw/register_file.sv
hw/processor.sv
sim/processor_tb.sv

/* Bender.yml */
package:
  name: rv5_pipe

sources:
  - hw/rv5_pkg.sv
  - hw/pipe_reg.sv
  - hw/if_stage.sv
  - hw/id_stage.sv
  - hw/ex_stage.sv
  - hw/mem_stage.sv
  - hw/register_file.sv
  - hw/processor.sv
  - target: simulation
    files:
      - sim/processor_tb.sv
